// File: bpu.f
rtl/bpu_pkg.sv
rtl/inst_predecode.sv
rtl/tage_hash.sv
rtl/bimodal_table.sv
rtl/tagged_table.sv
rtl/tage_arbiter.sv
rtl/btb.sv
rtl/bpu_top.sv
tests/bpu_tb.sv

// File: rtl/bimodal_table.sv
`timescale 1ns/1ps

module bimodal_table import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] pred_pc_i,
    input  logic [xlen-1:0] upd_pc_i,
    input  logic            upd_valid_i,
    input  logic            upd_taken_i,
    output ctr_t            pred_ctr_o
);

    localparam int entries = 512;

    ctr_t       ctr_mem [entries];
    logic [8:0] pred_idx;
    logic [8:0] upd_idx;
    ctr_t       upd_ctr;

    assign pred_idx = pred_pc_i[9:1]; // halfword granularity
    assign upd_idx  = upd_pc_i[9:1];
    assign upd_ctr  = ctr_mem[upd_idx];

    assign pred_ctr_o = ctr_mem[pred_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                ctr_mem[i] <= ctr_weak_nt;
            end
        end else if (upd_valid_i) begin
            if (upd_taken_i && upd_ctr != 2'd3) begin
                ctr_mem[upd_idx] <= upd_ctr + 2'd1;
            end else if (!upd_taken_i && upd_ctr != 2'd0) begin
                ctr_mem[upd_idx] <= upd_ctr - 2'd1;
            end
        end
    end

endmodule

// File: rtl/bpu_pkg.sv
package bpu_pkg;

    localparam int xlen = 32; // address and instruction width

    // 2-bit saturating counter, msb set means taken
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_weak_nt = 2'd1; // value after reset

    // instruction class seen by the predictor
    typedef enum logic [1:0] {
        op_branch,
        op_jal,
        op_jalr,
        op_other
    } opcode_e;

    // component that supplied the direction, tagged table k is prov_bimodal + 1 + k
    typedef enum logic [1:0] {
        prov_bimodal,
        prov_t0,
        prov_t1
    } provider_e;

    typedef enum logic [1:0] {
        upd_none,         // leave entry alone
        upd_saturate,     // step toward outcome
        upd_reset_strong, // jump to strong state of outcome
        upd_allocate      // new tag, weak state of outcome
    } upd_mode_e;

    // rv32 major opcodes
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

endpackage

// File: rtl/bpu_top.sv
`timescale 1ns/1ps

module bpu_top import bpu_pkg::*; #(
    parameter int HIST_WIDTH       = 16,
    parameter int TAGGED_TABLES    = 2,
    parameter int TAG_WIDTH        = 10,
    parameter int PARTIAL_TAG_BITS = 6,
    parameter int BTB_INDEX_WIDTH  = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [xlen-1:0]       if_pc_i,
    input  logic [xlen-1:0]       if_inst_i,
    input  logic                  ex_valid_i,
    input  logic                  ex_taken_i,
    input  logic                  ex_correct_i,
    input  logic [xlen-1:0]       ex_pc_i,
    input  logic [xlen-1:0]       ex_target_i,
    input  logic [HIST_WIDTH-1:0] ex_history_i,
    input  provider_e             ex_provider_i,
    output logic                  is_cti_o,
    output logic                  pred_taken_o,
    output logic [xlen-1:0]       pred_pc_o,
    output provider_e             provider_o,
    output logic [HIST_WIDTH-1:0] history_o
);

    logic [HIST_WIDTH-1:0] ghist_q;

    opcode_e         opcode;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] j_imm;
    logic [xlen-1:0] pc_plus4;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;
    ctr_t            bimodal_ctr;
    logic            pred_dir;

    logic [TAGGED_TABLES-1:0][7:0]           pred_index;
    logic [TAGGED_TABLES-1:0][7:0]           upd_index;
    logic [TAGGED_TABLES-1:0][TAG_WIDTH-1:0] pred_tag;
    logic [TAGGED_TABLES-1:0][TAG_WIDTH-1:0] upd_tag;
    logic [TAGGED_TABLES-1:0]                pred_hit;
    logic [TAGGED_TABLES-1:0]                upd_tag_hit;
    ctr_t [TAGGED_TABLES-1:0]                pred_ctr;
    upd_mode_e [TAGGED_TABLES-1:0]           upd_mode;

    // resolved outcomes enter at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (ex_valid_i) begin
            ghist_q <= {ghist_q[HIST_WIDTH-2:0], ex_taken_i};
        end
    end

    assign history_o = ghist_q;

    inst_predecode u_predecode (
        .if_inst_i (if_inst_i),
        .opcode_o  (opcode),
        .b_imm_o   (b_imm),
        .j_imm_o   (j_imm)
    );

    tage_hash #(
        .HIST_WIDTH    (HIST_WIDTH),
        .TAGGED_TABLES (TAGGED_TABLES),
        .TAG_WIDTH     (TAG_WIDTH)
    ) u_hash (
        .pred_pc_i    (if_pc_i),
        .upd_pc_i     (ex_pc_i),
        .pred_hist_i  (ghist_q),
        .upd_hist_i   (ex_history_i), // history seen when EX's insn was predicted
        .pred_index_o (pred_index),
        .upd_index_o  (upd_index),
        .pred_tag_o   (pred_tag),
        .upd_tag_o    (upd_tag)
    );

    bimodal_table u_bimodal (
        .clk         (clk),
        .rst         (rst),
        .pred_pc_i   (if_pc_i),
        .upd_pc_i    (ex_pc_i),
        .upd_valid_i (ex_valid_i),
        .upd_taken_i (ex_taken_i),
        .pred_ctr_o  (bimodal_ctr)
    );

    for (genvar k = 0; k < TAGGED_TABLES; k++) begin : g_tagged
        tagged_table #(
            .TAG_WIDTH        (TAG_WIDTH),
            .PARTIAL_TAG_BITS (PARTIAL_TAG_BITS)
        ) u_table (
            .clk           (clk),
            .rst           (rst),
            .pred_index_i  (pred_index[k]),
            .upd_index_i   (upd_index[k]),
            .pred_tag_i    (pred_tag[k]),
            .upd_tag_i     (upd_tag[k]),
            .upd_valid_i   (ex_valid_i),
            .upd_taken_i   (ex_taken_i),
            .upd_mode_i    (upd_mode[k]),
            .pred_hit_o    (pred_hit[k]),
            .pred_ctr_o    (pred_ctr[k]),
            .upd_tag_hit_o (upd_tag_hit[k])
        );
    end

    tage_arbiter #(
        .TAGGED_TABLES (TAGGED_TABLES)
    ) u_arbiter (
        .pred_hit_i     (pred_hit),
        .upd_tag_hit_i  (upd_tag_hit),
        .pred_ctr_i     (pred_ctr),
        .bimodal_ctr_i  (bimodal_ctr),
        .upd_valid_i    (ex_valid_i),
        .upd_correct_i  (ex_correct_i),
        .upd_provider_i (ex_provider_i),
        .provider_o     (provider_o),
        .pred_dir_o     (pred_dir),
        .upd_mode_o     (upd_mode)
    );

    btb #(
        .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH)
    ) u_btb (
        .clk          (clk),
        .rst          (rst),
        .pred_pc_i    (if_pc_i),
        .upd_pc_i     (ex_pc_i),
        .upd_target_i (ex_target_i),
        .upd_valid_i  (ex_valid_i),
        .upd_taken_i  (ex_taken_i),
        .hit_o        (btb_hit),
        .target_o     (btb_target)
    );

    assign pc_plus4 = if_pc_i + xlen'(4);

    always_comb begin
        is_cti_o     = 1'b0;
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;
        case (opcode)
            op_jal: begin
                is_cti_o     = 1'b1;
                pred_taken_o = 1'b1;
                pred_pc_o    = btb_hit ? btb_target : if_pc_i + j_imm;
            end
            op_branch: begin
                is_cti_o     = 1'b1;
                pred_taken_o = pred_dir;
                if (pred_dir) begin
                    pred_pc_o = btb_hit ? btb_target : if_pc_i + b_imm;
                end
            end
            op_jalr: begin
                is_cti_o = 1'b1;
                if (btb_hit) begin // no target without the btb
                    pred_taken_o = 1'b1;
                    pred_pc_o    = btb_target;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/btb.sv
`timescale 1ns/1ps

module btb import bpu_pkg::*; #(
    parameter int BTB_INDEX_WIDTH = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] pred_pc_i,
    input  logic [xlen-1:0] upd_pc_i,
    input  logic [xlen-1:0] upd_target_i,
    input  logic            upd_valid_i,
    input  logic            upd_taken_i,
    output logic            hit_o,
    output logic [xlen-1:0] target_o
);

    localparam int entries = 2 ** BTB_INDEX_WIDTH;
    localparam int tag_w   = xlen - BTB_INDEX_WIDTH - 2; // word aligned index

    logic [tag_w-1:0] tag_mem    [entries];
    logic [xlen-1:0]  target_mem [entries];
    logic             valid_q    [entries];

    logic [BTB_INDEX_WIDTH-1:0] pred_idx;
    logic [BTB_INDEX_WIDTH-1:0] upd_idx;
    logic [tag_w-1:0]           pred_tag;
    logic [tag_w-1:0]           upd_tag;

    assign pred_idx = pred_pc_i[BTB_INDEX_WIDTH+1:2];
    assign upd_idx  = upd_pc_i[BTB_INDEX_WIDTH+1:2];
    assign pred_tag = pred_pc_i[xlen-1:BTB_INDEX_WIDTH+2];
    assign upd_tag  = upd_pc_i[xlen-1:BTB_INDEX_WIDTH+2];

    assign hit_o    = valid_q[pred_idx] && (tag_mem[pred_idx] == pred_tag);
    assign target_o = target_mem[pred_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_valid_i && upd_taken_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // tag and target only written on taken updates
    always_ff @(posedge clk) begin
        if (upd_valid_i && upd_taken_i) begin
            tag_mem[upd_idx]    <= upd_tag;
            target_mem[upd_idx] <= upd_target_i;
        end
    end

endmodule

// File: rtl/inst_predecode.sv
`timescale 1ns/1ps

module inst_predecode import bpu_pkg::*; (
    input  logic [xlen-1:0] if_inst_i,
    output opcode_e         opcode_o,
    output logic [xlen-1:0] b_imm_o,
    output logic [xlen-1:0] j_imm_o
);

    always_comb begin
        case (if_inst_i[6:0])
            opc_branch: opcode_o = op_branch;
            opc_jal:    opcode_o = op_jal;
            opc_jalr:   opcode_o = op_jalr;
            default:    opcode_o = op_other;
        endcase
    end

    // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign b_imm_o = {{(xlen-12){if_inst_i[31]}},
                      if_inst_i[7],
                      if_inst_i[30:25],
                      if_inst_i[11:8],
                      1'b0};

    // J-type: imm[20|10:1|11|19:12]
    assign j_imm_o = {{(xlen-20){if_inst_i[31]}},
                      if_inst_i[19:12],
                      if_inst_i[20],
                      if_inst_i[30:21],
                      1'b0};

endmodule

// File: rtl/tage_arbiter.sv
`timescale 1ns/1ps

module tage_arbiter import bpu_pkg::*; #(
    parameter int TAGGED_TABLES = 2
) (
    input  logic [TAGGED_TABLES-1:0]      pred_hit_i,
    input  logic [TAGGED_TABLES-1:0]      upd_tag_hit_i,
    input  ctr_t [TAGGED_TABLES-1:0]      pred_ctr_i,
    input  ctr_t                          bimodal_ctr_i,
    input  logic                          upd_valid_i,
    input  logic                          upd_correct_i,
    input  provider_e                     upd_provider_i,
    output provider_e                     provider_o,
    output logic                          pred_dir_o,
    output upd_mode_e [TAGGED_TABLES-1:0] upd_mode_o
);

    // longest history that hits provides the direction
    always_comb begin
        provider_o = prov_bimodal;
        pred_dir_o = bimodal_ctr_i[1];
        for (int k = 0; k < TAGGED_TABLES; k++) begin
            if (pred_hit_i[k]) begin
                provider_o = provider_e'(k + 1);
                pred_dir_o = pred_ctr_i[k][1];
            end
        end
    end

    always_comb begin
        int alloc_sel;
        alloc_sel = -1;
        // highest table whose full tag misses, same as walking down from the top
        for (int k = 0; k < TAGGED_TABLES; k++) begin
            if (!upd_tag_hit_i[k]) alloc_sel = k;
        end
        for (int k = 0; k < TAGGED_TABLES; k++) begin
            upd_mode_o[k] = upd_none;
            if (upd_valid_i) begin
                if (int'(upd_provider_i) == k + 1) begin
                    upd_mode_o[k] = upd_correct_i ? upd_saturate : upd_reset_strong;
                end else if (upd_provider_i == prov_bimodal && !upd_correct_i
                             && alloc_sel == k) begin
                    upd_mode_o[k] = upd_allocate;
                end
            end
        end
    end

endmodule

// File: rtl/tage_hash.sv
`timescale 1ns/1ps

module tage_hash import bpu_pkg::*; #(
    parameter int HIST_WIDTH    = 16,
    parameter int TAGGED_TABLES = 2,
    parameter int TAG_WIDTH     = 10
) (
    input  logic [xlen-1:0]                          pred_pc_i,
    input  logic [xlen-1:0]                          upd_pc_i,
    input  logic [HIST_WIDTH-1:0]                    pred_hist_i,
    input  logic [HIST_WIDTH-1:0]                    upd_hist_i,
    output logic [TAGGED_TABLES-1:0][7:0]            pred_index_o,
    output logic [TAGGED_TABLES-1:0][7:0]            upd_index_o,
    output logic [TAGGED_TABLES-1:0][TAG_WIDTH-1:0]  pred_tag_o,
    output logic [TAGGED_TABLES-1:0][TAG_WIDTH-1:0]  upd_tag_o
);

    // pc bits above the index, xor the zero-extended history slice
    function automatic logic [TAG_WIDTH-1:0] fold_tag(
        input logic [xlen-1:0] pc,
        input logic [7:0]      slice
    );
        return pc[TAG_WIDTH+7:8] ^ {{(TAG_WIDTH-8){1'b0}}, slice};
    endfunction

    for (genvar k = 0; k < TAGGED_TABLES; k++) begin : g_hash
        // tag uses the slice of the next table, wrapping to t0
        localparam int nxt = (k + 1) % TAGGED_TABLES;

        logic [7:0] pred_slice;
        logic [7:0] pred_tag_slice;
        logic [7:0] upd_slice;
        logic [7:0] upd_tag_slice;

        assign pred_slice     = pred_hist_i[8*k +: 8];
        assign pred_tag_slice = pred_hist_i[8*nxt +: 8];
        assign upd_slice      = upd_hist_i[8*k +: 8];
        assign upd_tag_slice  = upd_hist_i[8*nxt +: 8];

        assign pred_index_o[k] = pred_pc_i[7:0] ^ pred_slice;
        assign upd_index_o[k]  = upd_pc_i[7:0] ^ upd_slice;

        assign pred_tag_o[k] = fold_tag(pred_pc_i, pred_tag_slice);
        assign upd_tag_o[k]  = fold_tag(upd_pc_i, upd_tag_slice);
    end

endmodule

// File: rtl/tagged_table.sv
`timescale 1ns/1ps

module tagged_table import bpu_pkg::*; #(
    parameter int TAG_WIDTH        = 10,
    parameter int PARTIAL_TAG_BITS = 6
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           pred_index_i,
    input  logic [7:0]           upd_index_i,
    input  logic [TAG_WIDTH-1:0] pred_tag_i,
    input  logic [TAG_WIDTH-1:0] upd_tag_i,
    input  logic                 upd_valid_i,
    input  logic                 upd_taken_i,
    input  upd_mode_e            upd_mode_i,
    output logic                 pred_hit_o,
    output ctr_t                 pred_ctr_o,
    output logic                 upd_tag_hit_o
);

    localparam int entries = 256;

    logic [TAG_WIDTH-1:0] tag_mem [entries];
    ctr_t                 ctr_mem [entries];

    logic [TAG_WIDTH-1:0] pred_entry_tag;
    ctr_t                 upd_ctr;

    assign pred_entry_tag = tag_mem[pred_index_i];
    assign upd_ctr        = ctr_mem[upd_index_i];

    // only the upper tag bits take part at predict time
    assign pred_hit_o = pred_entry_tag[TAG_WIDTH-1 -: PARTIAL_TAG_BITS]
                        == pred_tag_i[TAG_WIDTH-1 -: PARTIAL_TAG_BITS];
    assign pred_ctr_o = ctr_mem[pred_index_i];

    // full compare decides allocation
    assign upd_tag_hit_o = (tag_mem[upd_index_i] == upd_tag_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                tag_mem[i] <= '0;
                ctr_mem[i] <= ctr_weak_nt;
            end
        end else if (upd_valid_i) begin
            case (upd_mode_i)
                upd_saturate: begin
                    if (upd_taken_i && upd_ctr != 2'd3) begin
                        ctr_mem[upd_index_i] <= upd_ctr + 2'd1;
                    end else if (!upd_taken_i && upd_ctr != 2'd0) begin
                        ctr_mem[upd_index_i] <= upd_ctr - 2'd1;
                    end
                end
                upd_reset_strong: begin
                    ctr_mem[upd_index_i] <= upd_taken_i ? 2'd3 : 2'd0;
                end
                upd_allocate: begin
                    tag_mem[upd_index_i] <= upd_tag_i;
                    ctr_mem[upd_index_i] <= upd_taken_i ? 2'd2 : 2'd1; // weak toward outcome
                end
                default: ; // upd_none
            endcase
        end
    end

endmodule

// File: tests/bpu_tb.sv
`timescale 1ns/1ps

module bpu_tb import bpu_pkg::*; ();

    localparam int random_cycles   = 3000;
    localparam int directed_cycles = 16 + 70; // reset plus directed sequence, rounded up
    localparam int cycle_limit     = directed_cycles + random_cycles + 200;

    localparam logic [31:0] nop_pc   = 32'h0002_0000;
    localparam logic [31:0] nop_inst = 32'h0000_0013;
    localparam logic [31:0] pc_b     = 32'h0001_1040;
    localparam logic [31:0] pc_j     = 32'h0001_3000;
    localparam logic [31:0] pc_t     = 32'h0001_2080;
    localparam logic [31:0] pc_n     = 32'h0001_4404;
    localparam logic [31:0] pc_a     = 32'h0002_50c0;
    localparam logic [31:0] pc_r     = 32'h0003_0100;

    typedef struct packed {
        logic            is_cti;
        logic            taken;
        logic [xlen-1:0] target;
        provider_e       prov;
    } pred_t;

    logic            clk;
    logic            rst;
    logic [xlen-1:0] if_pc_i;
    logic [xlen-1:0] if_inst_i;
    logic            ex_valid_i;
    logic            ex_taken_i;
    logic            ex_correct_i;
    logic [xlen-1:0] ex_pc_i;
    logic [xlen-1:0] ex_target_i;
    logic [15:0]     ex_history_i;
    provider_e       ex_provider_i;
    logic            is_cti_o;
    logic            pred_taken_o;
    logic [xlen-1:0] pred_pc_o;
    provider_e       provider_o;
    logic [15:0]     history_o;

    // reference state
    logic [15:0] hist_m;
    ctr_t        bim_m   [512];
    logic [9:0]  ttag_m  [2][256];
    ctr_t        tctr_m  [2][256];
    logic        btb_v   [256];
    logic [21:0] btb_tag [256];
    logic [31:0] btb_tgt [256];

    // prediction waiting for its EX feedback
    logic        pend_valid;
    logic        pend_taken;
    logic        pend_correct;
    logic [31:0] pend_pc;
    logic [31:0] pend_target;
    logic [15:0] pend_hist;
    provider_e   pend_prov;

    pred_t       exp_pred;
    logic [15:0] exp_hist;
    logic        exp_valid;
    int          errors;
    int          cycle_cnt;

    logic [31:0] pool_pc   [16];
    logic [31:0] pool_inst [16];
    logic [31:0] pool_tgt  [16];
    logic        pool_bias [16];

    bpu_top DUT (
        .clk           (clk),
        .rst           (rst),
        .if_pc_i       (if_pc_i),
        .if_inst_i     (if_inst_i),
        .ex_valid_i    (ex_valid_i),
        .ex_taken_i    (ex_taken_i),
        .ex_correct_i  (ex_correct_i),
        .ex_pc_i       (ex_pc_i),
        .ex_target_i   (ex_target_i),
        .ex_history_i  (ex_history_i),
        .ex_provider_i (ex_provider_i),
        .is_cti_o      (is_cti_o),
        .pred_taken_o  (pred_taken_o),
        .pred_pc_o     (pred_pc_o),
        .provider_o    (provider_o),
        .history_o     (history_o)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        errors++;
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [xlen-1:0] exp_v,
                              input logic [xlen-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_history(input string name, input logic [15:0] exp_v,
                                 input logic [15:0] act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_provider(input string name, input provider_e exp_v,
                                  input provider_e act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH time=%0t %s expected=%s actual=%s (%b)", $time, name,
                     exp_v.name(), act_v.name(), act_v);
            abort_run();
        end
    endtask

    function automatic logic [31:0] imm_b(input logic [31:0] inst);
        logic [12:0] imm;
        imm = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        return {{19{imm[12]}}, imm};
    endfunction

    function automatic logic [31:0] imm_j(input logic [31:0] inst);
        logic [20:0] imm;
        imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        return {{11{imm[20]}}, imm};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic ctr_t step_ctr(input ctr_t c, input logic up);
        if (up) return (c == 2'd3) ? c : c + 2'd1;
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    // expected outputs from the predict rules and the reference state
    function automatic pred_t predict_ref(input logic [31:0] pc, input logic [31:0] inst);
        pred_t      p;
        logic       dir;
        logic [7:0] idx;
        logic [9:0] tag;
        logic [7:0] bi;
        logic       hit;
        p.is_cti = 1'b0;
        p.taken  = 1'b0;
        p.target = pc + 32'd4;
        p.prov   = prov_bimodal;
        dir      = bim_m[pc[9:1]][1];
        for (int k = 0; k < 2; k++) begin
            idx = pc[7:0] ^ hist_m[8*k +: 8];
            tag = pc[17:8] ^ {2'b00, hist_m[8*((k+1)%2) +: 8]};
            if (ttag_m[k][idx][9:4] == tag[9:4]) begin // partial tag only
                p.prov = provider_e'(k + 1);
                dir    = tctr_m[k][idx][1];
            end
        end
        bi  = pc[9:2];
        hit = btb_v[bi] && (btb_tag[bi] == pc[31:10]);
        case (inst[6:0])
            7'b1101111: begin
                p.is_cti = 1'b1;
                p.taken  = 1'b1;
                p.target = hit ? btb_tgt[bi] : pc + imm_j(inst);
            end
            7'b1100011: begin
                p.is_cti = 1'b1;
                p.taken  = dir;
                if (dir) p.target = hit ? btb_tgt[bi] : pc + imm_b(inst);
            end
            7'b1100111: begin
                p.is_cti = 1'b1;
                if (hit) begin
                    p.taken  = 1'b1;
                    p.target = btb_tgt[bi];
                end
            end
            default: ;
        endcase
        return p;
    endfunction

    task automatic model_update(input logic [31:0] pc, input logic taken, input logic correct,
                                input logic [31:0] target, input logic [15:0] hist,
                                input provider_e prov);
        logic [7:0] idx      [2];
        logic [9:0] tag      [2];
        logic       full_hit [2];
        logic       done;
        int         t;
        bim_m[pc[9:1]] = step_ctr(bim_m[pc[9:1]], taken);
        for (int k = 0; k < 2; k++) begin
            idx[k]      = pc[7:0] ^ hist[8*k +: 8];
            tag[k]      = pc[17:8] ^ {2'b00, hist[8*((k+1)%2) +: 8]};
            full_hit[k] = (ttag_m[k][idx[k]] == tag[k]);
        end
        if (prov != prov_bimodal) begin
            t = int'(prov) - 1;
            if (correct) tctr_m[t][idx[t]] = step_ctr(tctr_m[t][idx[t]], taken);
            else         tctr_m[t][idx[t]] = taken ? 2'd3 : 2'd0;
        end else if (!correct) begin
            done = 1'b0;
            for (int k = 1; k >= 0; k--) begin // last table first
                if (!done && !full_hit[k]) begin
                    ttag_m[k][idx[k]] = tag[k];
                    tctr_m[k][idx[k]] = taken ? 2'd2 : 2'd1;
                    done = 1'b1;
                end
            end
        end
        if (taken) begin
            btb_v[pc[9:2]]   = 1'b1;
            btb_tag[pc[9:2]] = pc[31:10];
            btb_tgt[pc[9:2]] = target;
        end
        hist_m = {hist_m[14:0], taken};
    endtask

    // one fetch cycle, feeding back the previous prediction
    task automatic fetch_cycle(input logic [31:0] pc, input logic [31:0] inst,
                               input logic outcome, input logic [31:0] target);
        @(posedge clk);
        #1;
        if (ex_valid_i) begin // consumed at this edge
            model_update(ex_pc_i, ex_taken_i, ex_correct_i, ex_target_i, ex_history_i,
                         ex_provider_i);
        end
        ex_valid_i    = pend_valid;
        ex_taken_i    = pend_taken;
        ex_correct_i  = pend_correct;
        ex_pc_i       = pend_pc;
        ex_target_i   = pend_target;
        ex_history_i  = pend_hist;
        ex_provider_i = pend_prov;
        if_pc_i       = pc;
        if_inst_i     = inst;
        exp_pred      = predict_ref(pc, inst);
        exp_hist      = hist_m;
        exp_valid     = 1'b1;
        pend_valid    = exp_pred.is_cti;
        pend_taken    = outcome;
        pend_correct  = (exp_pred.taken == outcome);
        pend_pc       = pc;
        pend_target   = target;
        pend_hist     = hist_m;
        pend_prov     = exp_pred.prov;
    endtask

    task automatic idle_cycle();
        fetch_cycle(nop_pc, nop_inst, 1'b0, 32'h0);
    endtask

    // hand-derived values, checked late in the cycle
    task automatic expect_pred(input logic cti, input logic taken, input logic [31:0] target);
        #6;
        check_bit("is_cti_o", cti, is_cti_o);
        check_bit("pred_taken_o", taken, pred_taken_o);
        check_addr("pred_pc_o", target, pred_pc_o);
    endtask

    // sixteen not-taken updates clear the history
    task automatic clear_history();
        repeat (16) fetch_cycle(pc_n, enc_branch(13'h010), 1'b0, pc_n + 32'h10);
        idle_cycle();
    endtask

    always begin
        @(posedge clk);
        #7;
        if (exp_valid) begin
            check_bit("is_cti_o", exp_pred.is_cti, is_cti_o);
            check_bit("pred_taken_o", exp_pred.taken, pred_taken_o);
            check_addr("pred_pc_o", exp_pred.target, pred_pc_o);
            check_provider("provider_o", exp_pred.prov, provider_o);
            check_history("history_o", exp_hist, history_o);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        int unsigned seed_val;
        int unsigned raw;
        int          sel;
        logic        outcome;
        logic [31:0] target;
        seed_val      = $urandom(32'h8ed23052);
        clk           = 1'b0;
        rst           = 1'b1;
        if_pc_i       = nop_pc;
        if_inst_i     = nop_inst;
        ex_valid_i    = 1'b0;
        ex_taken_i    = 1'b0;
        ex_correct_i  = 1'b0;
        ex_pc_i       = '0;
        ex_target_i   = '0;
        ex_history_i  = '0;
        ex_provider_i = prov_bimodal;
        pend_valid    = 1'b0;
        exp_valid     = 1'b0;
        errors        = 0;
        cycle_cnt     = 0;
        hist_m        = '0;
        for (int i = 0; i < 512; i++) bim_m[i] = ctr_weak_nt;
        for (int i = 0; i < 256; i++) begin
            ttag_m[0][i] = '0;
            ttag_m[1][i] = '0;
            tctr_m[0][i] = ctr_weak_nt;
            tctr_m[1][i] = ctr_weak_nt;
            btb_v[i]     = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        // after reset
        fetch_cycle(pc_b, enc_branch(13'h020), 1'b0, pc_b + 32'h20);
        expect_pred(1'b1, 1'b0, pc_b + 32'd4);
        check_provider("provider_o", prov_bimodal, provider_o);
        check_history("history_o", 16'h0, history_o);
        idle_cycle();
        expect_pred(1'b0, 1'b0, nop_pc + 32'd4);

        // jal, then btb target after a taken update
        fetch_cycle(pc_j, enc_jal(21'h100), 1'b1, 32'h0000_4000);
        expect_pred(1'b1, 1'b1, pc_j + 32'h100);
        idle_cycle();
        fetch_cycle(pc_j, enc_jal(21'h100), 1'b1, 32'h0000_4000);
        expect_pred(1'b1, 1'b1, 32'h0000_4000);

        // bimodal training
        fetch_cycle(pc_t, enc_branch(13'h040), 1'b1, pc_t + 32'h40);
        expect_pred(1'b1, 1'b0, pc_t + 32'd4);
        idle_cycle();
        fetch_cycle(pc_t, enc_branch(13'h040), 1'b1, pc_t + 32'h40);
        idle_cycle();
        fetch_cycle(pc_t, enc_branch(13'h040), 1'b1, pc_t + 32'h40);
        expect_pred(1'b1, 1'b1, pc_t + 32'h40);

        // allocation in T1, then strong reset on a T1 miss
        clear_history();
        fetch_cycle(pc_a, enc_branch(13'h040), 1'b1, pc_a + 32'h40);
        expect_pred(1'b1, 1'b0, pc_a + 32'd4);
        check_provider("provider_o", prov_bimodal, provider_o);
        clear_history();
        fetch_cycle(pc_a, enc_branch(13'h040), 1'b1, pc_a + 32'h40);
        expect_pred(1'b1, 1'b1, pc_a + 32'h40);
        check_provider("provider_o", prov_t1, provider_o);
        idle_cycle();
        // counter at 3 now, a single step down would still predict taken
        fetch_cycle(pc_a, enc_branch(13'h040), 1'b0, pc_a + 32'h40);
        expect_pred(1'b1, 1'b1, pc_a + 32'h40);
        check_provider("provider_o", prov_t1, provider_o);
        idle_cycle();
        fetch_cycle(pc_a, enc_branch(13'h040), 1'b0, pc_a + 32'h40);
        expect_pred(1'b1, 1'b0, pc_a + 32'd4);
        check_provider("provider_o", prov_t1, provider_o);

        // outcomes 1 0 1 1 shift in behind the 1 0 0 of pc_a
        fetch_cycle(pc_n, enc_branch(13'h010), 1'b1, pc_n + 32'h10);
        fetch_cycle(pc_n, enc_branch(13'h010), 1'b0, pc_n + 32'h10);
        fetch_cycle(pc_n, enc_branch(13'h010), 1'b1, pc_n + 32'h10);
        fetch_cycle(pc_n, enc_branch(13'h010), 1'b1, pc_n + 32'h10);
        idle_cycle();
        idle_cycle();
        #6 check_history("history_o", 16'h004b, history_o);

        // jalr needs the btb
        fetch_cycle(pc_r, 32'h0000_80e7, 1'b1, 32'h0000_8000);
        expect_pred(1'b1, 1'b0, pc_r + 32'd4);
        idle_cycle();
        fetch_cycle(pc_r, 32'h0000_80e7, 1'b1, 32'h0000_8000);
        expect_pred(1'b1, 1'b1, 32'h0000_8000);

        // random mix over a small pc pool
        for (int i = 0; i < 16; i++) begin
            raw          = $urandom;
            pool_pc[i]   = $urandom & 32'h000f_fffc;
            pool_tgt[i]  = $urandom & 32'hffff_fffc;
            pool_bias[i] = raw[0];
            case ($urandom % 4)
                0:       pool_inst[i] = {raw[31:7], 7'b1100011};
                1:       pool_inst[i] = {raw[31:7], 7'b1101111};
                2:       pool_inst[i] = {raw[31:7], 7'b1100111};
                default: pool_inst[i] = {raw[31:7], 7'b0010011};
            endcase
        end
        for (int n = 0; n < random_cycles; n++) begin
            sel = $urandom % 16;
            case (pool_inst[sel][6:0])
                7'b1100011: begin
                    outcome = ($urandom % 8 != 0) ? pool_bias[sel] : !pool_bias[sel];
                    target  = pool_pc[sel] + imm_b(pool_inst[sel]);
                end
                7'b1101111: begin
                    outcome = 1'b1;
                    target  = pool_pc[sel] + imm_j(pool_inst[sel]);
                end
                7'b1100111: begin
                    outcome = 1'b1;
                    target  = pool_tgt[sel];
                end
                default: begin
                    outcome = 1'b0;
                    target  = '0;
                end
            endcase
            fetch_cycle(pool_pc[sel], pool_inst[sel], outcome, target);
        end
        idle_cycle();
        idle_cycle();
        #7;

        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule
